// File: src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first instruction after reset, start of the boot ROM
`define FETCH_RESET_PC    32'h3000_0000

// one cache block is this many 32-bit words
`define FETCH_BLOCK_WORDS 4

// lines in the direct-mapped instruction cache
`define FETCH_CACHE_SETS  16

// SDRAM answers INCR bursts, the rest of the map only single reads
`define FETCH_SDRAM_BASE  32'hA000_0000
`define FETCH_SDRAM_END   32'hBFFF_FFFF

`endif

// File: src/fetch_pkg.sv
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;                                // byte address
    typedef logic [31:0] word_t;                                // instruction or data word
    typedef logic [`FETCH_BLOCK_WORDS*32-1:0] block_t;          // word 0 sits in the low bits

    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_out_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    typedef struct packed {
        block_t data;
        logic   fault;                                          // fill ended on an error response
    } fill_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        READ
    } fetch_state_t;

endpackage

`default_nettype wire

// File: src/ifu.sv
`default_nettype none
`include "fetch_settings.svh"

module ifu
    import fetch_pkg::*;
(
    input  wire            clk,
    input  wire            rst,

    input  wire            decode_ready,
    input  wire redirect_t redirect,
    output logic           fetch_valid,
    output fetch_out_t     fetch,
    output logic           access_fault,

    output addr_t          lookup_pc,
    input  wire            hit,
    input  wire word_t     hit_inst,
    input  wire            fill_req,
    output logic           fill_done,
    output fill_t          fill,

    output logic           ar_valid,
    output axi_ar_t        ar,
    input  wire            ar_ready,
    input  wire            r_valid,
    input  wire axi_r_t    r,
    output logic           r_ready
);

    localparam int BEAT_W = $clog2(`FETCH_BLOCK_WORDS);
    localparam int OFF_W  = BEAT_W + 2;                         // byte offset bits inside a block

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    fetch_state_t      state;
    addr_t             pc;
    addr_t             next_pc;
    addr_t             block_base;
    addr_t             ar_addr;
    logic              is_sdram;
    logic              deliver;
    logic              ar_fire;
    logic              r_fire;
    logic              resp_err;
    logic              last_beat;
    logic [BEAT_W-1:0] beat_cnt;
    logic [BEAT_W-1:0] beat_next;
    block_t            fill_data;
    logic              fill_fault;

    assign lookup_pc  = pc;
    assign next_pc    = redirect.valid ? redirect.target : pc + 32'd4;
    assign block_base = {pc[31:OFF_W], {OFF_W{1'b0}}};
    assign is_sdram   = (block_base >= `FETCH_SDRAM_BASE) && (block_base <= `FETCH_SDRAM_END);

    // a fetch leaves on a hit in IDLE or right after a fill
    assign deliver = ((state == IDLE) && decode_ready && hit) || (state == READ);

    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign resp_err  = r.resp != RESP_OKAY;
    assign beat_next = beat_cnt + 1'b1;
    assign last_beat = is_sdram ? r.last : (beat_cnt == BEAT_W'(`FETCH_BLOCK_WORDS - 1));

    assign fill = '{data: fill_data, fault: fill_fault};

    // pc does not move during a fill, so the burst shape stays stable
    always_comb begin
        ar.addr  = ar_addr;
        ar.id    = 4'h0;
        ar.len   = is_sdram ? 8'(`FETCH_BLOCK_WORDS - 1) : 8'h00;
        ar.size  = 3'd2;                                        // 4 bytes per beat
        ar.burst = is_sdram ? BURST_INCR : BURST_FIXED;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            pc           <= `FETCH_RESET_PC;
            fetch_valid  <= 1'b0;
            access_fault <= 1'b0;
            ar_valid     <= 1'b0;
            r_ready      <= 1'b0;
            fill_done    <= 1'b0;
            fill_fault   <= 1'b0;
            beat_cnt     <= '0;
        end else begin
            fetch_valid  <= 1'b0;
            access_fault <= 1'b0;
            fill_done    <= 1'b0;
            case (state)
                IDLE: begin
                    if (decode_ready && hit) begin
                        fetch_valid <= 1'b1;
                        pc          <= next_pc;
                    end else if (decode_ready && fill_req) begin
                        state      <= BUSY;
                        ar_valid   <= 1'b1;
                        fill_fault <= 1'b0;
                        beat_cnt   <= '0;
                    end
                end
                BUSY: begin
                    if (ar_fire) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (fill_done) begin
                        state <= READ;                          // the line is written on this edge
                    end else if (r_fire) begin
                        if (resp_err || last_beat) begin
                            fill_fault <= resp_err;
                            fill_done  <= 1'b1;
                            r_ready    <= 1'b0;
                        end else begin
                            beat_cnt <= beat_next;
                            if (!is_sdram) begin
                                ar_valid <= 1'b1;               // single reads need one AR per word
                            end
                        end
                    end
                end
                READ: begin
                    state        <= IDLE;
                    fetch_valid  <= 1'b1;
                    access_fault <= fill_fault;
                    pc           <= next_pc;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            fetch <= '{pc: pc, inst: hit_inst};
        end
        if (state == IDLE) begin
            ar_addr <= block_base;
        end else if ((state == BUSY) && r_fire && !is_sdram) begin
            ar_addr <= {pc[31:OFF_W], beat_next, 2'b00};
        end
        if ((state == BUSY) && r_fire) begin
            fill_data[beat_cnt*32 +: 32] <= r.data;
        end
    end

    // the slave may sample ar on any cycle it chooses to accept
    ar_hold_a: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    fill_done_busy_a: assert property (@(posedge clk) disable iff (rst)
        fill_done |-> state != IDLE);

endmodule

`default_nettype wire

// File: src/icache.sv
`default_nettype none
`include "fetch_settings.svh"

module icache
    import fetch_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    input  wire addr_t lookup_pc,
    output logic       hit,
    output word_t      hit_inst,
    output logic       fill_req,

    input  wire        fill_done,
    input  wire fill_t fill
);

    localparam int SETS   = `FETCH_CACHE_SETS;
    localparam int IDX_W  = $clog2(SETS);
    localparam int WORD_W = $clog2(`FETCH_BLOCK_WORDS);
    localparam int OFF_W  = WORD_W + 2;
    localparam int TAG_W  = 32 - OFF_W - IDX_W;

    logic [SETS-1:0]   valid;
    logic [TAG_W-1:0]  tag_mem [SETS];
    block_t            data_mem [SETS];

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WORD_W-1:0] word_sel;
    block_t            line;
    logic              write_en;

    // pc = tag | index | word | byte
    assign idx      = lookup_pc[OFF_W +: IDX_W];
    assign tag      = lookup_pc[31 -: TAG_W];
    assign word_sel = lookup_pc[2 +: WORD_W];

    assign line     = data_mem[idx];
    assign hit      = valid[idx] && (tag_mem[idx] == tag);
    assign hit_inst = line[word_sel*32 +: 32];
    assign fill_req = !hit;

    // a faulted fill leaves the line as it was
    assign write_en = fill_done && !fill.fault;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (write_en) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= fill.data;                         // lookup_pc still points at the miss
        end
    end

    // the fetch unit only fills after a miss and holds the pc until the line is written
    fill_on_miss_a: assert property (@(posedge clk) disable iff (rst)
        fill_done |-> !hit);

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  wire            clk,
    input  wire            rst,

    output logic           fetch_valid,
    output fetch_out_t     fetch,
    output logic           access_fault,
    input  wire            decode_ready,

    input  wire redirect_t redirect,

    output logic           ar_valid,
    output axi_ar_t        ar,
    input  wire            ar_ready,
    input  wire            r_valid,
    input  wire axi_r_t    r,
    output logic           r_ready
);

    addr_t lookup_pc;
    logic  hit;
    word_t hit_inst;
    logic  fill_req;
    logic  fill_done;
    fill_t fill;

    ifu u_ifu (
        .clk          (clk),
        .rst          (rst),
        .decode_ready (decode_ready),
        .redirect     (redirect),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .access_fault (access_fault),
        .lookup_pc    (lookup_pc),
        .hit          (hit),
        .hit_inst     (hit_inst),
        .fill_req     (fill_req),
        .fill_done    (fill_done),
        .fill         (fill),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready)
    );

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (lookup_pc),
        .hit       (hit),
        .hit_inst  (hit_inst),
        .fill_req  (fill_req),
        .fill_done (fill_done),
        .fill      (fill)
    );

endmodule

`default_nettype wire

// File: tb/axi_rom_model.sv
`default_nettype none
`include "fetch_settings.svh"

module axi_rom_model
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED = 32'd48106
)
(
    input  wire          clk,
    input  wire          rst,
    input  wire          ar_valid,
    input  wire axi_ar_t ar,
    output logic         ar_ready,
    output logic         r_valid,
    output axi_r_t       r,
    input  wire          r_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] ERR_LO     = 32'h3000_0100;
    localparam logic [31:0] ERR_HI     = 32'h3000_013F;
    localparam logic [1:0]  BURST_INCR = 2'b01;

    logic [31:0] rand_state;
    logic        busy;
    logic        incr;
    logic [31:0] beat_addr;
    logic [7:0]  beats_left;
    logic [3:0]  cur_id;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]} ^ 32'hC0DE_0000;
    endfunction

    function automatic logic is_error_addr(input logic [31:0] a);
        return (a >= ERR_LO) && (a <= ERR_HI);
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rand_state = SEED;
            ar_ready   <= 1'b0;
            r_valid    <= 1'b0;
            r          <= '0;
            busy       <= 1'b0;
            incr       <= 1'b0;
            beat_addr  <= '0;
            beats_left <= '0;
            cur_id     <= '0;
        end else begin
            rand_state = lcg_next(rand_state);
            if (!busy) begin
                if (ar_valid && ar_ready) begin
                    busy       <= 1'b1;
                    incr       <= ar.burst == BURST_INCR;
                    beat_addr  <= ar.addr;
                    beats_left <= ar.len;
                    cur_id     <= ar.id;
                    ar_ready   <= 1'b0;                     // one outstanding burst at a time
                    $display("axi: AR addr %h len %0d burst %0d size %0d",
                             ar.addr, ar.len, ar.burst, ar.size);
                end else begin
                    ar_ready <= rand_state[16] | rand_state[17];
                end
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                if (r.last) begin
                    busy <= 1'b0;
                end else begin
                    if (incr) begin
                        beat_addr <= beat_addr + 32'd4;
                    end
                    beats_left <= beats_left - 8'd1;
                end
            end else if (!r_valid && rand_state[18]) begin  // roughly half the cycles stall
                r_valid <= 1'b1;
                r       <= '{data: rom_word(beat_addr),
                             resp: is_error_addr(beat_addr) ? 2'b10 : 2'b00,
                             last: beats_left == 8'd0,
                             id:   cur_id};
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/fetch_tb.sv
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FETCHES = 400;
    localparam int TIMEOUT     = 2000;
    localparam int WORDS       = `FETCH_BLOCK_WORDS;
    localparam int SETS        = `FETCH_CACHE_SETS;
    localparam int OFF_W       = $clog2(WORDS) + 2;
    localparam int IDX_W       = $clog2(SETS);
    localparam logic [31:0] ERR_LO = 32'h3000_0100;
    localparam logic [31:0] ERR_HI = 32'h3000_013F;

    logic        clk;
    logic        rst;
    logic        decode_ready;
    redirect_t   redirect;
    logic        fetch_valid;
    fetch_out_t  fetch;
    logic        access_fault;
    logic        ar_valid;
    axi_ar_t     ar;
    logic        ar_ready;
    logic        r_valid;
    axi_r_t      r;
    logic        r_ready;

    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          fetch_count;
    int          idle_cycles;
    logic        fetch_seen;
    addr_t       exp_pc;
    redirect_t   used_redirect;                             // value the DUT sees on the coming edge
    axi_ar_t     ar_q[$];
    logic        tag_valid [SETS];
    logic [31:0] tag_store [SETS];

    fetch_top UUT (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .access_fault (access_fault),
        .decode_ready (decode_ready),
        .redirect     (redirect),
        .ar_valid     (ar_valid),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r            (r),
        .r_ready      (r_ready)
    );

    axi_rom_model #(.SEED(32'd48106)) rom (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r        (r),
        .r_ready  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // same mixing of the address as the ROM holds
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[7:0], a[31:8]} ^ 32'hC0DE_0000;
    endfunction

    function automatic logic is_error_addr(input logic [31:0] a);
        return (a >= ERR_LO) && (a <= ERR_HI);
    endfunction

    function automatic logic in_sdram(input logic [31:0] a);
        return (a >= `FETCH_SDRAM_BASE) && (a <= `FETCH_SDRAM_END);
    endfunction

    // the fill reads beats up to and including the first error response
    function automatic int fill_beats(input logic [31:0] base);
        int beats;
        beats = WORDS;
        for (int i = WORDS - 1; i >= 0; i--) begin
            if (is_error_addr(base + 32'(4 * i))) begin
                beats = i + 1;
            end
        end
        return beats;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_ar_traffic(input addr_t base, input logic hit_exp);
        int beats;
        beats = fill_beats(base);
        if (hit_exp) begin
            check_value("ar transfer count", 32'(ar_q.size()), 32'd0);
        end else if (in_sdram(base)) begin
            check_value("ar transfer count", 32'(ar_q.size()), 32'd1);
            if (ar_q.size() > 0) begin
                check_value("ar.addr", ar_q[0].addr, base);
                check_value("ar.len", 32'(ar_q[0].len), 32'(WORDS - 1));
                check_value("ar.burst", 32'(ar_q[0].burst), 32'd1);
                check_value("ar.size", 32'(ar_q[0].size), 32'd2);
                check_value("ar.id", 32'(ar_q[0].id), 32'd0);
            end
        end else begin
            check_value("ar transfer count", 32'(ar_q.size()), 32'(beats));
            for (int i = 0; i < beats && i < ar_q.size(); i++) begin
                check_value("ar.addr", ar_q[i].addr, base + 32'(4 * i));
                check_value("ar.len", 32'(ar_q[i].len), 32'd0);
                check_value("ar.burst", 32'(ar_q[i].burst), 32'd0);
                check_value("ar.size", 32'(ar_q[i].size), 32'd2);
                check_value("ar.id", 32'(ar_q[i].id), 32'd0);
            end
        end
    endtask

    task automatic check_delivery();
        addr_t       pc;
        addr_t       base;
        int          idx;
        logic [31:0] tag;
        logic        hit_exp;
        logic        fault_exp;
        pc        = fetch.pc;                               // later fetches follow the DUT's pc
        base      = {pc[31:OFF_W], {OFF_W{1'b0}}};
        idx       = int'(pc[OFF_W +: IDX_W]);
        tag       = pc >> (OFF_W + IDX_W);
        hit_exp   = tag_valid[idx] && (tag_store[idx] == tag);
        fault_exp = fill_beats(base) < WORDS || is_error_addr(base + 32'(4 * (WORDS - 1)));
        check_value("fetch.pc", pc, exp_pc);
        check_value("access_fault", 32'(access_fault), 32'(fault_exp));
        check_ar_traffic(base, hit_exp);
        if (!fault_exp) begin
            check_value("fetch.inst", fetch.inst, expected_word(pc));
            tag_valid[idx] = 1'b1;
            tag_store[idx] = tag;
        end
        ar_q.delete();
        exp_pc = used_redirect.valid ? used_redirect.target : pc + 32'd4;
    endtask

    task automatic drive_inputs();
        addr_t target;
        rand_state = lcg_next(rand_state);
        decode_ready <= rand_state[17:16] != 2'b00;         // high about three cycles in four
        if (fetch_seen) begin
            rand_state = lcg_next(rand_state);
            if (rand_state[29]) begin
                target = `FETCH_SDRAM_BASE + {22'd0, rand_state[27:20], 2'b00};
            end else begin
                target = 32'h3000_0000 + {23'd0, rand_state[26:20], 2'b00};
            end
            if (rand_state[31:30] == 2'b00) begin
                redirect <= '{valid: 1'b1, target: target};
            end else begin
                redirect <= '{valid: 1'b0, target: '0};
            end
        end
    endtask

    initial begin
        rst           <= 1'b1;
        decode_ready  <= 1'b0;
        redirect      <= '0;
        rand_state    = 32'd48106;
        errors        = 0;
        checks        = 0;
        fetch_count   = 0;
        idle_cycles   = 0;
        fetch_seen    = 1'b0;
        exp_pc        = `FETCH_RESET_PC;
        used_redirect = '0;
        for (int i = 0; i < SETS; i++) begin
            tag_valid[i] = 1'b0;
            tag_store[i] = '0;
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        repeat (4) begin                                    // decode_ready is still low here
            @(negedge clk);
            check_value("fetch_valid", 32'(fetch_valid), 32'd0);
            check_value("ar_valid", 32'(ar_valid), 32'd0);
            check_value("r_ready", 32'(r_ready), 32'd0);
            check_value("access_fault", 32'(access_fault), 32'd0);
        end

        while (fetch_count < NUM_FETCHES && idle_cycles < TIMEOUT) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            if (ar_valid && ar_ready) begin
                ar_q.push_back(ar);                         // the transfer happens on the next edge
            end
            fetch_seen = fetch_valid;
            if (fetch_valid) begin
                check_delivery();
                fetch_count++;
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
            used_redirect = redirect;
        end

        if (idle_cycles >= TIMEOUT) begin
            errors++;
            $display("timeout: no fetch delivered for %0d cycles after fetch %0d",
                     TIMEOUT, fetch_count);
        end
        $display("fetches: %0d, checks: %0d, errors: %0d", fetch_count, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/fetch_pkg.sv
src/ifu.sv
src/icache.sv
src/fetch_top.sv
tb/axi_rom_model.sv
tb/fetch_tb.sv

// File: Makefile
SIM  := obj_dir/Vfetch_tb
SRCS := $(shell grep -v '^+' vlog.f) src/fetch_settings.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f vlog.f

run: $(SIM)
	./$(SIM) > run.log 2>&1 ; status=$$? ; cat run.log ; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" run.log ; then \
		echo "simulation did not pass, see run.log" ; exit 1 ; \
	fi

clean:
	rm -rf obj_dir run.log
